// ==== flist.f ====
+incdir+rtl
+incdir+tests
rtl/decode_pkg.sv
rtl/op_decoder.sv
rtl/imm_gen.sv
rtl/hazard_unit.sv
rtl/operand_fwd.sv
rtl/decode_stage.sv
tests/tb_decode.sv

// ==== tests/tb_decode_table.svh ====
`ifndef TB_DECODE_TABLE_SVH
`define TB_DECODE_TABLE_SVH

// Columns: instruction word, PC, expected operation, expected immediate,
// immediate is the second operand, expected exception flags {illegal, misaligned, fault}

typedef struct packed {
    logic [`XLEN-1:0]       instr;
    logic [`XLEN-1:0]       pc;
    decode_pkg::op_e        op;
    logic [`XLEN-1:0]       imm;
    logic                   imm_second;
    decode_pkg::exc_flags_t exc;
} table_row_t;

localparam int num_rows = 12;

localparam table_row_t decode_rows [num_rows] = '{
    // lui x5, 0x12345
    '{32'h123452b7, 32'h00001000, decode_pkg::LUI,    32'h12345000, 1'b1, 3'b000},
    // beq x1, x2, -8
    '{32'hfe208ce3, 32'h00001004, decode_pkg::BEQ,    32'hfffffff8, 1'b0, 3'b000},
    // addi x6, x1, -5
    '{32'hffb08313, 32'h00001008, decode_pkg::ADD,    32'hfffffffb, 1'b1, 3'b000},
    // sw x7, 20(x2)
    '{32'h00712a23, 32'h0000100c, decode_pkg::SW,     32'h00000014, 1'b1, 3'b000},
    // mul x8, x3, x4
    '{32'h02418433, 32'h00001010, decode_pkg::MUL,    32'h00000000, 1'b0, 3'b000},
    // csrrw x9, mtvec, x10
    '{32'h305514f3, 32'h00001014, decode_pkg::CSRRW,  32'h00000000, 1'b0, 3'b000},
    // fence iorw, iorw
    '{32'h0ff0000f, 32'h00001018, decode_pkg::NOP,    32'h00000000, 1'b0, 3'b000},
    // jal x1, +16
    '{32'h010000ef, 32'h0000101c, decode_pkg::JAL,    32'h00000010, 1'b0, 3'b000},
    // auipc x3, 0xfffff
    '{32'hfffff197, 32'h00001020, decode_pkg::AUIPC,  32'hfffff000, 1'b1, 3'b000},
    // Unknown major opcode 11111
    '{32'h0000007f, 32'h00001024, decode_pkg::INVALID, 32'h00000000, 1'b0, 3'b100},
    // addi x0, x0, 0 at a PC ending in 01
    '{32'h00000013, 32'h00001029, decode_pkg::ADD,    32'h00000000, 1'b1, 3'b010},
    // addi x2, x2, 4 with a fetch fault
    '{32'h00410113, 32'h0000102c, decode_pkg::ADD,    32'h00000004, 1'b1, 3'b001}
};

`endif

// ==== tests/tb_decode.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module tb_decode;

    `include "tb_decode_table.svh"

    localparam int directed_cycles = 32;
    localparam int run_cycles      = num_rows + directed_cycles + 3 + 20;   // Reset and margin

    logic                    clk;
    logic                    reset_n;
    logic                    enable;
    logic                    sys_reset;
    logic [`XLEN-1:0]        instruction;
    logic [`XLEN-1:0]        pc;
    logic                    access_fault;
    logic [`XLEN-1:0]        rs1_rdata;
    logic [`XLEN-1:0]        rs2_rdata;
    decode_pkg::fwd_port_t   exec_fwd;
    decode_pkg::fwd_port_t   retire_fwd;
    logic                    rollback;
    logic                    jumping;
    logic                    ctx_switch;
    logic                    jump_misaligned;
    logic [`REG_AW-1:0]      rs1;
    logic [`REG_AW-1:0]      rs2;
    logic                    hazard;
    decode_pkg::decode_out_t dec;

    logic                    hazard_seen;
    logic [31:0]             lfsr_state;
    logic [`XLEN-1:0]        word;
    int                      checks;
    int                      errors;

    decode_stage #(.m_enable(1'b1)) decode_stage_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .enable_i          (enable),
        .sys_reset_i       (sys_reset),
        .instruction_i     (instruction),
        .pc_i              (pc),
        .access_fault_i    (access_fault),
        .rs1_rdata_i       (rs1_rdata),
        .rs2_rdata_i       (rs2_rdata),
        .exec_fwd_i        (exec_fwd),
        .retire_fwd_i      (retire_fwd),
        .rollback_i        (rollback),
        .jumping_i         (jumping),
        .ctx_switch_i      (ctx_switch),
        .jump_misaligned_i (jump_misaligned),
        .rs1_o             (rs1),
        .rs2_o             (rs2),
        .hazard_o          (hazard),
        .dec_o             (dec)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Galois form, taps 32 22 2 1
    task automatic rand_word(output logic [`XLEN-1:0] w);
        for (int b = 0; b < `XLEN; b++) begin
            w          = {lfsr_state[0], w[`XLEN-1:1]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic decode_step(input logic [`XLEN-1:0] instr, input logic [`XLEN-1:0] addr);
        instruction = instr;
        pc          = addr;
        rand_word(rs1_rdata);
        rand_word(rs2_rdata);
        #25;
        hazard_seen = hazard;   // Settled, well before the rising edge
        check_val("rs1_o", rs1, instr[19:15]);
        check_val("rs2_o", rs2, instr[24:20]);
        @(negedge clk);
    endtask

    task automatic expect_step(input logic [`XLEN-1:0] instr, input logic [`XLEN-1:0] addr,
                               input logic exp_hazard, input decode_pkg::op_e exp_op,
                               input logic exp_killed);
        decode_step(instr, addr);
        check_val("hazard_o", hazard_seen, exp_hazard);
        check_val("dec_o.op", dec.op, exp_op);
        check_val("dec_o.killed", dec.killed, exp_killed);
    endtask

    initial begin
        #(run_cycles * 100);
        $display("timeout: the stimulus did not complete in the allowed time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        reset_n         = 1'b0;
        enable          = 1'b1;
        sys_reset       = 1'b0;
        instruction     = 32'h00000013;
        pc              = 32'h00001000;
        access_fault    = 1'b0;
        rs1_rdata       = '0;
        rs2_rdata       = '0;
        exec_fwd        = '0;
        retire_fwd      = '0;
        rollback        = 1'b0;
        jumping         = 1'b0;
        ctx_switch      = 1'b0;
        jump_misaligned = 1'b0;
        lfsr_state      = 32'hd01cc805;
        checks          = 0;
        errors          = 0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Table of single instructions
        for (int i = 0; i < num_rows; i++) begin
            access_fault = decode_rows[i].exc.access_fault;
            decode_step(decode_rows[i].instr, decode_rows[i].pc);
            check_val("hazard_o", hazard_seen, 1'b0);
            check_val("dec_o.op", dec.op, decode_rows[i].op);
            check_val("dec_o.second", dec.second,
                      decode_rows[i].imm_second ? decode_rows[i].imm : rs2_rdata);
            check_val("dec_o.target", dec.target, decode_rows[i].pc + decode_rows[i].imm);
            check_val("dec_o.rd", dec.rd, decode_rows[i].instr[11:7]);
            check_val("dec_o.instr_rs1", dec.instr_rs1, decode_rows[i].instr[19:15]);
            check_val("dec_o.csr_addr", dec.csr_addr, decode_rows[i].instr[31:20]);
            check_val("dec_o.rs1_data", dec.rs1_data, rs1_rdata);
            check_val("dec_o.exc", dec.exc, decode_rows[i].exc);
            check_val("dec_o.killed", dec.killed, 1'b0);
        end
        access_fault = 1'b0;

        //////////////////////////////////////////////////
        // Load-use and store-load hazards
        //////////////////////////////////////////////////

        expect_step(32'h0000a283, 32'h00002000, 1'b0, decode_pkg::LW, 1'b0);    // lw x5
        expect_step(32'h00028333, 32'h00002004, 1'b1, decode_pkg::NOP, 1'b0);   // add x6,x5,x0
        expect_step(32'h00028333, 32'h00002004, 1'b0, decode_pkg::ADD, 1'b0);
        expect_step(32'h0000a283, 32'h00002008, 1'b0, decode_pkg::LW, 1'b0);
        expect_step(32'h000012b7, 32'h0000200c, 1'b0, decode_pkg::LUI, 1'b0);   // Writes x5 only
        expect_step(32'h00712a23, 32'h00002010, 1'b0, decode_pkg::SW, 1'b0);
        expect_step(32'h0000a283, 32'h00002014, 1'b1, decode_pkg::NOP, 1'b0);
        expect_step(32'h0000a283, 32'h00002014, 1'b0, decode_pkg::LW, 1'b0);

        // Exceptions hide the hazard on x5
        expect_step(32'h0002807f, 32'h00002018, 1'b0, decode_pkg::INVALID, 1'b0);
        check_val("dec_o.exc", dec.exc, 3'b100);
        expect_step(32'h0000a283, 32'h0000201c, 1'b0, decode_pkg::LW, 1'b0);
        expect_step(32'h00028333, 32'h00002021, 1'b0, decode_pkg::ADD, 1'b0);
        check_val("dec_o.exc", dec.exc, 3'b010);
        expect_step(32'h0000a283, 32'h00002024, 1'b0, decode_pkg::LW, 1'b0);
        access_fault = 1'b1;
        expect_step(32'h00028333, 32'h00002028, 1'b0, decode_pkg::ADD, 1'b0);
        check_val("dec_o.exc", dec.exc, 3'b001);
        access_fault = 1'b0;

        //////////////////////////////////////////////////
        // Forwarding priority
        //////////////////////////////////////////////////

        expect_step(32'h00100393, 32'h00002100, 1'b0, decode_pkg::ADD, 1'b0);   // addi x7,x0,1
        rand_word(word);
        exec_fwd = '{1'b1, 5'd0, word};      // rd field ignored by the stage
        rand_word(word);
        retire_fwd = '{1'b1, 5'd7, word};
        expect_step(32'h00738433, 32'h00002104, 1'b0, decode_pkg::ADD, 1'b0);   // add x8,x7,x7
        check_val("dec_o.rs1_data", dec.rs1_data, exec_fwd.data);
        check_val("dec_o.rs2_data", dec.rs2_data, exec_fwd.data);
        check_val("dec_o.second", dec.second, exec_fwd.data);
        expect_step(32'h00738433, 32'h00002108, 1'b0, decode_pkg::ADD, 1'b0);   // Prior rd now x8
        check_val("dec_o.rs1_data", dec.rs1_data, retire_fwd.data);
        check_val("dec_o.rs2_data", dec.rs2_data, retire_fwd.data);
        retire_fwd.rd = 5'd3;
        expect_step(32'h00738433, 32'h0000210c, 1'b0, decode_pkg::ADD, 1'b0);
        check_val("dec_o.rs1_data", dec.rs1_data, rs1_rdata);
        check_val("dec_o.rs2_data", dec.rs2_data, rs2_rdata);
        exec_fwd   = '0;
        retire_fwd = '0;

        // Each kill source alone, on an instruction that would otherwise stall
        for (int k = 0; k < 4; k++) begin
            expect_step(32'h0000a283, 32'h00002200 + k * 8, 1'b0, decode_pkg::LW, 1'b0);
            {rollback, jumping, ctx_switch, jump_misaligned} = 4'b1000 >> k;
            expect_step(32'h00028333, 32'h00002204 + k * 8, 1'b0, decode_pkg::NOP, 1'b1);
            {rollback, jumping, ctx_switch, jump_misaligned} = 4'b0000;
        end

        //////////////////////////////////////////////////
        // Hold and flush
        //////////////////////////////////////////////////

        expect_step(32'h00100393, 32'h00002300, 1'b0, decode_pkg::ADD, 1'b0);
        enable = 1'b0;
        decode_step(32'h123452b7, 32'h00002304);
        check_val("dec_o.pc", dec.pc, 32'h00002300);
        check_val("dec_o.instruction", dec.instruction, 32'h00100393);
        check_val("dec_o.op", dec.op, decode_pkg::ADD);
        check_val("dec_o.second", dec.second, 32'h00000001);
        enable    = 1'b1;
        sys_reset = 1'b1;
        decode_step(32'h00738433, 32'h00002308);
        check_val("dec_o.op", dec.op, decode_pkg::NOP);
        check_val("dec_o.pc", dec.pc, 32'h00002308);
        sys_reset = 1'b0;

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== rtl/decode_stage.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module decode_stage #(
    parameter bit m_enable = 1'b1
) (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    enable_i,
    input  logic                    sys_reset_i,
    input  logic [`XLEN-1:0]        instruction_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic                    access_fault_i,
    input  logic [`XLEN-1:0]        rs1_rdata_i,
    input  logic [`XLEN-1:0]        rs2_rdata_i,
    input  decode_pkg::fwd_port_t   exec_fwd_i,
    input  decode_pkg::fwd_port_t   retire_fwd_i,
    input  logic                    rollback_i,
    input  logic                    jumping_i,
    input  logic                    ctx_switch_i,
    input  logic                    jump_misaligned_i,
    output logic [`REG_AW-1:0]      rs1_o,
    output logic [`REG_AW-1:0]      rs2_o,
    output logic                    hazard_o,
    output decode_pkg::decode_out_t dec_o
);

    decode_pkg::op_e         op;
    decode_pkg::format_e     fmt;
    decode_pkg::exc_flags_t  exc;
    decode_pkg::decode_out_t dec_d;
    logic [`XLEN-1:0]        imm;
    logic [`XLEN-1:0]        target;
    logic [`XLEN-1:0]        rs1_data;
    logic [`XLEN-1:0]        rs2_data;
    logic [`XLEN-1:0]        second;
    logic                    killed;
    logic                    exception;

    assign rs1_o = instruction_i[`RS1_MSB:`RS1_LSB];   // Straight to the register bank
    assign rs2_o = instruction_i[`RS2_MSB:`RS2_LSB];

    op_decoder #(.m_enable(m_enable)) op_decoder_i (
        .instruction_i (instruction_i),
        .op_o          (op),
        .format_o      (fmt)
    );

    imm_gen imm_gen_i (
        .instruction_i (instruction_i),
        .format_i      (fmt),
        .pc_i          (pc_i),
        .imm_o         (imm),
        .target_o      (target)
    );

    hazard_unit hazard_unit_i (
        .clk               (clk),
        .reset_n           (reset_n),
        .enable_i          (enable_i),
        .instruction_i     (instruction_i),
        .op_i              (op),
        .format_i          (fmt),
        .exception_i       (exception),
        .rollback_i        (rollback_i),
        .jumping_i         (jumping_i),
        .ctx_switch_i      (ctx_switch_i),
        .jump_misaligned_i (jump_misaligned_i),
        .hazard_o          (hazard_o),
        .killed_o          (killed)
    );

    operand_fwd operand_fwd_i (
        .rs1_i        (rs1_o),
        .rs2_i        (rs2_o),
        .rd_prev_i    (dec_o.rd),
        .exec_fwd_i   (exec_fwd_i),
        .retire_fwd_i (retire_fwd_i),
        .rs1_rdata_i  (rs1_rdata_i),
        .rs2_rdata_i  (rs2_rdata_i),
        .format_i     (fmt),
        .imm_i        (imm),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .second_o     (second)
    );

    //////////////////////////////////////////////////
    // Exceptions and the register toward execute
    //////////////////////////////////////////////////

    always_comb begin
        exc.illegal      = (op == decode_pkg::INVALID);
        exc.misaligned   = (pc_i[1:0] != 2'b00);   // No compressed fetch
        exc.access_fault = access_fault_i;
        exception        = exc.illegal || exc.misaligned || exc.access_fault;
    end

    always_comb begin
        dec_d.pc          = pc_i;
        dec_d.instruction = instruction_i;
        dec_d.op          = (hazard_o || killed) ? decode_pkg::NOP : op;   // Bubble
        dec_d.rs1_data    = rs1_data;
        dec_d.rs2_data    = rs2_data;
        dec_d.second      = second;
        dec_d.target      = target;
        dec_d.rd          = instruction_i[`RD_MSB:`RD_LSB];
        dec_d.instr_rs1   = rs1_o;
        dec_d.csr_addr    = instruction_i[`CSR_MSB:`CSR_LSB];
        dec_d.killed      = killed;
        dec_d.exc         = exc;
    end

    // rd also feeds back to the forwarding muxes
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dec_o    <= '0;
            dec_o.op <= decode_pkg::NOP;
        end else begin
            if (enable_i)
                dec_o <= dec_d;
            if (sys_reset_i)
                dec_o.op <= decode_pkg::NOP;   // Flush wins over hold
        end
    end

endmodule

// ==== rtl/operand_fwd.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module operand_fwd (
    input  logic [`REG_AW-1:0]    rs1_i,
    input  logic [`REG_AW-1:0]    rs2_i,
    input  logic [`REG_AW-1:0]    rd_prev_i,
    input  decode_pkg::fwd_port_t exec_fwd_i,
    input  decode_pkg::fwd_port_t retire_fwd_i,
    input  logic [`XLEN-1:0]      rs1_rdata_i,
    input  logic [`XLEN-1:0]      rs2_rdata_i,
    input  decode_pkg::format_e   format_i,
    input  logic [`XLEN-1:0]      imm_i,
    output logic [`XLEN-1:0]      rs1_data_o,
    output logic [`XLEN-1:0]      rs2_data_o,
    output logic [`XLEN-1:0]      second_o
);

    // Execute result first, then retire writeback, then bank read
    function automatic logic [`XLEN-1:0] fwd_select(
        input logic [`REG_AW-1:0]    rs,
        input logic [`REG_AW-1:0]    rd_prev,
        input decode_pkg::fwd_port_t exe,
        input decode_pkg::fwd_port_t ret,
        input logic [`XLEN-1:0]      bank
    );
        if (exe.we && rs == rd_prev)
            return exe.data;        // Own registered rd, exe.rd not needed
        else if (ret.we && rs == ret.rd)
            return ret.data;
        else
            return bank;
    endfunction

    always_comb begin
        rs1_data_o = fwd_select(rs1_i, rd_prev_i, exec_fwd_i, retire_fwd_i, rs1_rdata_i);
        rs2_data_o = fwd_select(rs2_i, rd_prev_i, exec_fwd_i, retire_fwd_i, rs2_rdata_i);
    end

    always_comb begin
        unique case (format_i)
            decode_pkg::FMT_I,
            decode_pkg::FMT_S,
            decode_pkg::FMT_U: second_o = imm_i;
            default:           second_o = rs2_data_o;
        endcase
    end

endmodule

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module hazard_unit (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                enable_i,
    input  logic [`XLEN-1:0]    instruction_i,
    input  decode_pkg::op_e     op_i,
    input  decode_pkg::format_e format_i,
    input  logic                exception_i,
    input  logic                rollback_i,
    input  logic                jumping_i,
    input  logic                ctx_switch_i,
    input  logic                jump_misaligned_i,
    output logic                hazard_o,
    output logic                killed_o
);

    logic [`REG_AW-1:0] rd;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] locked_reg;
    logic               locked_mem;
    logic               is_load;
    logic               is_store;
    logic               use_rs1;
    logic               use_rs2;

    assign rd  = instruction_i[`RD_MSB:`RD_LSB];
    assign rs1 = instruction_i[`RS1_MSB:`RS1_LSB];
    assign rs2 = instruction_i[`RS2_MSB:`RS2_LSB];

    assign is_load  = op_i inside {decode_pkg::LB, decode_pkg::LH, decode_pkg::LW,
                                   decode_pkg::LBU, decode_pkg::LHU};
    assign is_store = op_i inside {decode_pkg::SB, decode_pkg::SH, decode_pkg::SW};

    // Jumps are confirmed without prediction
    assign killed_o = rollback_i || jumping_i || ctx_switch_i || jump_misaligned_i;

    always_comb begin
        use_rs1 = format_i inside {decode_pkg::FMT_R, decode_pkg::FMT_B,
                                   decode_pkg::FMT_S, decode_pkg::FMT_I};
        use_rs2 = format_i inside {decode_pkg::FMT_R, decode_pkg::FMT_B, decode_pkg::FMT_S};
    end

    assign hazard_o = ((use_rs1 && locked_reg != '0 && rs1 == locked_reg)
                    || (use_rs2 && locked_reg != '0 && rs2 == locked_reg)
                    || (is_load && locked_mem))
                    && !killed_o && !exception_i;

    //////////////////////////////////////////////////
    // One-entry lock, load data and store completion
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
        end else if (enable_i) begin
            if (hazard_o || killed_o) begin   // Bubble leaves nothing pending
                locked_reg <= '0;
                locked_mem <= 1'b0;
            end else begin
                locked_reg <= is_load ? rd : '0;
                locked_mem <= is_store;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) !(hazard_o && killed_o))
        else $error("hazard_o and killed_o high together");

endmodule

// ==== rtl/imm_gen.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module imm_gen (
    input  logic [`XLEN-1:0]    instruction_i,
    input  decode_pkg::format_e format_i,
    input  logic [`XLEN-1:0]    pc_i,
    output logic [`XLEN-1:0]    imm_o,
    output logic [`XLEN-1:0]    target_o
);

    logic [`XLEN-1:0] imm_itype;
    logic [`XLEN-1:0] imm_stype;
    logic [`XLEN-1:0] imm_btype;
    logic [`XLEN-1:0] imm_utype;
    logic [`XLEN-1:0] imm_jtype;

    // All immediates sign-extend from bit 31
    assign imm_itype = {{21{instruction_i[31]}}, instruction_i[30:20]};
    assign imm_stype = {{21{instruction_i[31]}}, instruction_i[30:25], instruction_i[11:7]};
    assign imm_btype = {{20{instruction_i[31]}}, instruction_i[7], instruction_i[30:25],
                        instruction_i[11:8], 1'b0};
    assign imm_utype = {instruction_i[31:12], 12'b0};
    assign imm_jtype = {{12{instruction_i[31]}}, instruction_i[19:12], instruction_i[20],
                        instruction_i[30:21], 1'b0};

    always_comb begin
        unique case (format_i)
            decode_pkg::FMT_I: imm_o = imm_itype;
            decode_pkg::FMT_S: imm_o = imm_stype;
            decode_pkg::FMT_B: imm_o = imm_btype;
            decode_pkg::FMT_U: imm_o = imm_utype;
            decode_pkg::FMT_J: imm_o = imm_jtype;
            default:           imm_o = '0;         // R format
        endcase
    end

    // Branch and JAL target, computed here so execute needs no adder for it
    assign target_o = pc_i + imm_o;

endmodule

// ==== rtl/op_decoder.sv ====
`timescale 1ns/10ps
`include "decode_consts.svh"

module op_decoder #(
    parameter bit m_enable = 1'b1
) (
    input  logic [`XLEN-1:0]    instruction_i,
    output decode_pkg::op_e     op_o,
    output decode_pkg::format_e format_o
);

    decode_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    decode_pkg::op_e     dec_branch;
    decode_pkg::op_e     dec_load;
    decode_pkg::op_e     dec_store;
    decode_pkg::op_e     dec_op_imm;
    decode_pkg::op_e     dec_op;
    decode_pkg::op_e     dec_system;

    assign opcode = decode_pkg::opcode_e'(instruction_i[`OPC_MSB:`OPC_LSB]);
    assign funct3 = instruction_i[`F3_MSB:`F3_LSB];
    assign funct7 = instruction_i[`F7_MSB:`F7_LSB];

    //////////////////////////////////////////////////
    // Sub-decoders by funct fields
    //////////////////////////////////////////////////

    always_comb begin
        unique case (funct3)
            3'b000:  dec_branch = decode_pkg::BEQ;
            3'b001:  dec_branch = decode_pkg::BNE;
            3'b100:  dec_branch = decode_pkg::BLT;
            3'b101:  dec_branch = decode_pkg::BGE;
            3'b110:  dec_branch = decode_pkg::BLTU;
            3'b111:  dec_branch = decode_pkg::BGEU;
            default: dec_branch = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  dec_load = decode_pkg::LB;
            3'b001:  dec_load = decode_pkg::LH;
            3'b010:  dec_load = decode_pkg::LW;
            3'b100:  dec_load = decode_pkg::LBU;
            3'b101:  dec_load = decode_pkg::LHU;
            default: dec_load = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  dec_store = decode_pkg::SB;
            3'b001:  dec_store = decode_pkg::SH;
            3'b010:  dec_store = decode_pkg::SW;
            default: dec_store = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        unique case ({funct7, funct3}) inside
            10'b???????000: dec_op_imm = decode_pkg::ADD;   // ADDI
            10'b0000000001: dec_op_imm = decode_pkg::SLL;   // Shift amount in rs2 field
            10'b???????010: dec_op_imm = decode_pkg::SLT;
            10'b???????011: dec_op_imm = decode_pkg::SLTU;
            10'b???????100: dec_op_imm = decode_pkg::XOR;
            10'b0000000101: dec_op_imm = decode_pkg::SRL;
            10'b0100000101: dec_op_imm = decode_pkg::SRA;
            10'b???????110: dec_op_imm = decode_pkg::OR;
            10'b???????111: dec_op_imm = decode_pkg::AND;
            default:        dec_op_imm = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        unique case ({funct7, funct3})
            10'b0000000000: dec_op = decode_pkg::ADD;
            10'b0100000000: dec_op = decode_pkg::SUB;
            10'b0000000001: dec_op = decode_pkg::SLL;
            10'b0000000010: dec_op = decode_pkg::SLT;
            10'b0000000011: dec_op = decode_pkg::SLTU;
            10'b0000000100: dec_op = decode_pkg::XOR;
            10'b0000000101: dec_op = decode_pkg::SRL;
            10'b0100000101: dec_op = decode_pkg::SRA;
            10'b0000000110: dec_op = decode_pkg::OR;
            10'b0000000111: dec_op = decode_pkg::AND;
            // M extension
            10'b0000001000: dec_op = m_enable ? decode_pkg::MUL    : decode_pkg::INVALID;
            10'b0000001001: dec_op = m_enable ? decode_pkg::MULH   : decode_pkg::INVALID;
            10'b0000001010: dec_op = m_enable ? decode_pkg::MULHSU : decode_pkg::INVALID;
            10'b0000001011: dec_op = m_enable ? decode_pkg::MULHU  : decode_pkg::INVALID;
            10'b0000001100: dec_op = m_enable ? decode_pkg::DIV    : decode_pkg::INVALID;
            10'b0000001101: dec_op = m_enable ? decode_pkg::DIVU   : decode_pkg::INVALID;
            10'b0000001110: dec_op = m_enable ? decode_pkg::REM    : decode_pkg::INVALID;
            10'b0000001111: dec_op = m_enable ? decode_pkg::REMU   : decode_pkg::INVALID;
            default:        dec_op = decode_pkg::INVALID;
        endcase
    end

    always_comb begin
        unique case (instruction_i[31:7]) inside
            25'b000000000000_00000_000_00000: dec_system = decode_pkg::ECALL;
            25'b000000000001_00000_000_00000: dec_system = decode_pkg::EBREAK;
            25'b000100000010_00000_000_00000: dec_system = decode_pkg::SRET;
            25'b001100000010_00000_000_00000: dec_system = decode_pkg::MRET;
            25'b000100000101_00000_000_00000: dec_system = decode_pkg::WFI;
            25'b????????????_?????_001_?????: dec_system = decode_pkg::CSRRW;
            25'b????????????_?????_010_?????: dec_system = decode_pkg::CSRRS;
            25'b????????????_?????_011_?????: dec_system = decode_pkg::CSRRC;
            25'b????????????_?????_101_?????: dec_system = decode_pkg::CSRRWI;
            25'b????????????_?????_110_?????: dec_system = decode_pkg::CSRRSI;
            25'b????????????_?????_111_?????: dec_system = decode_pkg::CSRRCI;
            default:                          dec_system = decode_pkg::INVALID;
        endcase
    end

    //////////////////////////////////////////////////
    // Operation and format
    //////////////////////////////////////////////////

    always_comb begin
        op_o     = decode_pkg::INVALID;
        format_o = decode_pkg::FMT_R;   // SYSTEM, MISC-MEM and OP
        case (opcode)
            decode_pkg::OPC_LUI:      begin op_o = decode_pkg::LUI;   format_o = decode_pkg::FMT_U; end
            decode_pkg::OPC_AUIPC:    begin op_o = decode_pkg::AUIPC; format_o = decode_pkg::FMT_U; end
            decode_pkg::OPC_JAL:      begin op_o = decode_pkg::JAL;   format_o = decode_pkg::FMT_J; end
            decode_pkg::OPC_JALR:     begin op_o = decode_pkg::JALR;  format_o = decode_pkg::FMT_I; end
            decode_pkg::OPC_BRANCH:   begin op_o = dec_branch;        format_o = decode_pkg::FMT_B; end
            decode_pkg::OPC_LOAD:     begin op_o = dec_load;          format_o = decode_pkg::FMT_I; end
            decode_pkg::OPC_STORE:    begin op_o = dec_store;         format_o = decode_pkg::FMT_S; end
            decode_pkg::OPC_OP_IMM:   begin op_o = dec_op_imm;        format_o = decode_pkg::FMT_I; end
            decode_pkg::OPC_OP:       op_o = dec_op;
            decode_pkg::OPC_SYSTEM:   op_o = dec_system;
            decode_pkg::OPC_MISC_MEM: op_o = (funct3 == 3'b000) ? decode_pkg::NOP  // FENCE
                                                                : decode_pkg::INVALID;
            default:                  op_o = decode_pkg::INVALID;
        endcase
        if (instruction_i[1:0] != 2'b11)
            op_o = decode_pkg::INVALID;     // Not a 32-bit encoding
    end

    // Sampled on each new instruction, so the pair checked is a settled one
    assert property (@(instruction_i) !$isunknown(instruction_i) |-> !$isunknown(format_o))
        else $error("format_o unknown for a known instruction");

endmodule

// ==== rtl/decode_pkg.sv ====
`include "decode_consts.svh"

package decode_pkg;

    // Decoded operation handed to execute
    typedef enum logic [5:0] {
        NOP, LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        ECALL, EBREAK, SRET, MRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        INVALID
    } op_e;

    // Major opcodes, instruction bits 6..2
    typedef enum logic [`OPC_W-1:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011,
        OPC_SYSTEM   = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {FMT_R, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J} format_e;

    typedef struct packed {
        logic               we;
        logic [`REG_AW-1:0] rd;
        logic [`XLEN-1:0]   data;
    } fwd_port_t;

    typedef struct packed {
        logic illegal;
        logic misaligned;
        logic access_fault;
    } exc_flags_t;

    // Everything registered toward execute
    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [`XLEN-1:0]   instruction;
        op_e                op;
        logic [`XLEN-1:0]   rs1_data;
        logic [`XLEN-1:0]   rs2_data;
        logic [`XLEN-1:0]   second;
        logic [`XLEN-1:0]   target;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] instr_rs1;
        logic [`CSR_AW-1:0] csr_addr;
        logic               killed;
        exc_flags_t         exc;
    } decode_out_t;

endpackage

// ==== rtl/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Datapath and register file
`define XLEN    32
`define REG_AW  5
`define CSR_AW  12
`define OPC_W   5

// Instruction field bounds
`define OPC_MSB 6
`define OPC_LSB 2
`define RD_MSB  11
`define RD_LSB  7
`define F3_MSB  14
`define F3_LSB  12
`define RS1_MSB 19
`define RS1_LSB 15
`define RS2_MSB 24
`define RS2_LSB 20
`define F7_MSB  31
`define F7_LSB  25
`define CSR_MSB 31
`define CSR_LSB 20

`endif
